// ==== verilog/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [7:0]  hw_int_t;

    // CSR numbers
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECFG   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    // CRMD fields
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATM_LO = 7;
    localparam int CRMD_DATM_HI = 8;

    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PPLV_HI = 1;
    localparam int PRMD_PIE     = 2;

    localparam int ECFG_LIE_HI = 12;

    localparam int ESTAT_IS_LO       = 0;
    localparam int ESTAT_IS_HI       = 12;
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ECODE_HI    = 21;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int ESTAT_ESUBCODE_HI = 30;

    // Interrupt line positions inside IS and LIE
    localparam int INT_SOFT_HI = 1;
    localparam int INT_HW_LO   = 2;
    localparam int INT_HW_HI   = 9;
    localparam int INT_TIMER   = 11;

    localparam int EENTRY_VA_LO = 6;

    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;

    localparam int TICLR_CLR = 0;

endpackage

`default_nettype wire

// ==== verilog/csr_mode.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_mode (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire                     wen,
    input  wire csr_pkg::csr_data_t wdata,
    input  wire                     exception,
    input  wire                     ertn,
    input  wire csr_pkg::ecode_t    ecode_in,
    input  wire csr_pkg::esubcode_t esubcode_in,
    input  wire csr_pkg::hw_int_t   hw_int,
    input  wire                     timer_pending,
    output csr_pkg::csr_data_t      crmd,
    output csr_pkg::csr_data_t      prmd,
    output csr_pkg::csr_data_t      ecfg,
    output csr_pkg::csr_data_t      estat,
    output csr_pkg::plv_t           plv,
    output logic                    cpu_interrupt,
    output logic                    idle_over
);
    import csr_pkg::*;

    plv_t       plv_q;
    logic       ie_q;
    logic       da_q;
    logic       pg_q;
    logic [1:0] datf_q;
    logic [1:0] datm_q;
    plv_t       pplv_q;
    logic       pie_q;
    int_vec_t   lie_q;
    logic [1:0] soft_q;
    ecode_t     ecode_q;
    esubcode_t  esubcode_q;
    int_vec_t   estat_is;
    logic       crmd_wr;
    logic       prmd_wr;
    logic       ecfg_wr;
    logic       estat_wr;

    assign crmd_wr  = wen && (addr == CSR_CRMD);
    assign prmd_wr  = wen && (addr == CSR_PRMD);
    assign ecfg_wr  = wen && (addr == CSR_ECFG);
    assign estat_wr = wen && (addr == CSR_ESTAT);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            plv_q  <= '0;
            ie_q   <= 1'b0;
            da_q   <= 1'b1;
            pg_q   <= 1'b0;
            datf_q <= '0;
            datm_q <= '0;
        end else if (ertn) begin
            plv_q <= pplv_q;
            ie_q  <= pie_q;
        end else if (exception) begin
            plv_q <= '0;
            ie_q  <= 1'b0;
        end else if (crmd_wr) begin
            plv_q  <= wdata[CRMD_PLV_HI:CRMD_PLV_LO];
            ie_q   <= wdata[CRMD_IE];
            datf_q <= wdata[CRMD_DATF_HI:CRMD_DATF_LO];
            datm_q <= wdata[CRMD_DATM_HI:CRMD_DATM_LO];
            // Translation mode moves only to a legal DA/PG pair
            if (wdata[CRMD_DA] ^ wdata[CRMD_PG]) begin
                da_q <= wdata[CRMD_DA];
                pg_q <= wdata[CRMD_PG];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pplv_q <= '0;
            pie_q  <= 1'b0;
        end else if (exception) begin
            pplv_q <= plv_q;
            pie_q  <= ie_q;
        end else if (prmd_wr) begin
            pplv_q <= wdata[PRMD_PPLV_HI:PRMD_PPLV_LO];
            pie_q  <= wdata[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            lie_q <= '0;
        end else if (ecfg_wr) begin
            lie_q <= wdata[ECFG_LIE_HI:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else if (exception) begin
            ecode_q    <= ecode_in;
            esubcode_q <= (ecode_in == '0) ? '0 : esubcode_in;
        end
    end

    // Only the two software lines are writable
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            soft_q <= '0;
        end else if (estat_wr) begin
            soft_q <= wdata[INT_SOFT_HI:0];
        end
    end

    always_comb begin
        estat_is = '0;
        estat_is[INT_SOFT_HI:0] = soft_q;
        estat_is[INT_HW_HI:INT_HW_LO] = hw_int;
        estat_is[INT_TIMER] = timer_pending;
    end

    always_comb begin
        crmd = '0;
        crmd[CRMD_PLV_HI:CRMD_PLV_LO]   = plv_q;
        crmd[CRMD_IE]                   = ie_q;
        crmd[CRMD_DA]                   = da_q;
        crmd[CRMD_PG]                   = pg_q;
        crmd[CRMD_DATF_HI:CRMD_DATF_LO] = datf_q;
        crmd[CRMD_DATM_HI:CRMD_DATM_LO] = datm_q;
    end

    always_comb begin
        estat = '0;
        estat[ESTAT_IS_HI:ESTAT_IS_LO]             = estat_is;
        estat[ESTAT_ECODE_HI:ESTAT_ECODE_LO]       = ecode_q;
        estat[ESTAT_ESUBCODE_HI:ESTAT_ESUBCODE_LO] = esubcode_q;
    end

    assign prmd = {29'b0, pie_q, pplv_q};
    assign ecfg = {19'b0, lie_q};
    assign plv  = plv_q;

    assign cpu_interrupt = ie_q & (|(lie_q & estat_is));
    // Any pending line wakes the core, enabled or not
    assign idle_over = |estat_is;

endmodule

`default_nettype wire

// ==== verilog/csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire                     wen,
    input  wire csr_pkg::csr_data_t wdata,
    output csr_pkg::csr_data_t      tcfg,
    output csr_pkg::csr_data_t      tval,
    output logic                    timer_pending
);
    import csr_pkg::*;

    logic                        en_q;
    logic                        periodic_q;
    logic [31:TCFG_INITVAL_LO]   initval_q;
    csr_data_t                   tval_q;
    logic                        pending_q;
    logic                        tcfg_wr;
    logic                        ticlr_wr;
    logic                        tval_expire;

    assign tcfg_wr  = wen && (addr == CSR_TCFG);
    assign ticlr_wr = wen && (addr == CSR_TICLR) && wdata[TICLR_CLR];

    // Count really steps from 1 to 0 at this edge
    assign tval_expire = en_q && (tval_q == 32'd1) && !tcfg_wr;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            en_q       <= 1'b0;
            periodic_q <= 1'b0;
            initval_q  <= '0;
        end else if (tcfg_wr) begin
            en_q       <= wdata[TCFG_EN];
            periodic_q <= wdata[TCFG_PERIODIC];
            initval_q  <= wdata[31:TCFG_INITVAL_LO];
        end
    end

    // Load value is one above the programmed count so INITVAL 0 still fires
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval_q <= '0;
        end else if (tcfg_wr) begin
            tval_q <= {wdata[31:TCFG_INITVAL_LO], 2'b01};
        end else if (tval_q == '0) begin
            if (periodic_q) begin
                tval_q <= {initval_q, 2'b01};
            end
        end else if (en_q) begin
            tval_q <= tval_q - 32'd1;
        end
    end

    // Set beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pending_q <= 1'b0;
        end else if (tval_expire) begin
            pending_q <= 1'b1;
        end else if (ticlr_wr) begin
            pending_q <= 1'b0;
        end
    end

    assign tcfg          = {initval_q, periodic_q, en_q};
    assign tval          = tval_q;
    assign timer_pending = pending_q;

endmodule

`default_nettype wire

// ==== verilog/csr_storage.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_storage #(
    parameter int N_SAVE = 4
) (
    input  wire                     clk,
    input  wire                     aresetn,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire                     wen,
    input  wire csr_pkg::csr_data_t wdata,
    input  wire                     exception,
    input  wire csr_pkg::csr_data_t era_in,
    output csr_pkg::csr_data_t      era,
    output csr_pkg::csr_data_t      eentry,
    output csr_pkg::csr_data_t      save [N_SAVE]
);
    import csr_pkg::*;

    csr_data_t              era_q;
    logic [31:EENTRY_VA_LO] eentry_va_q;

    // Exception entry takes the return address over a software write
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era_q <= '0;
        end else if (exception) begin
            era_q <= era_in;
        end else if (wen && (addr == CSR_ERA)) begin
            era_q <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            eentry_va_q <= '0;
        end else if (wen && (addr == CSR_EENTRY)) begin
            eentry_va_q <= wdata[31:EENTRY_VA_LO];
        end
    end

    // Scratch words at consecutive numbers from SAVE0
    for (genvar i = 0; i < N_SAVE; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (!aresetn) begin
                save[i] <= '0;
            end else if (wen && (addr == csr_addr_t'(CSR_SAVE0 + i))) begin
                save[i] <= wdata;
            end
        end
    end

    assign era    = era_q;
    assign eentry = {eentry_va_q, 6'b0};

endmodule

`default_nettype wire

// ==== verilog/csr_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux #(
    parameter int N_SAVE = 4
) (
    input  wire csr_pkg::csr_addr_t addr,
    input  wire csr_pkg::csr_data_t crmd,
    input  wire csr_pkg::csr_data_t prmd,
    input  wire csr_pkg::csr_data_t ecfg,
    input  wire csr_pkg::csr_data_t estat,
    input  wire csr_pkg::csr_data_t era,
    input  wire csr_pkg::csr_data_t eentry,
    input  wire csr_pkg::csr_data_t save [N_SAVE],
    input  wire csr_pkg::csr_data_t tcfg,
    input  wire csr_pkg::csr_data_t tval,
    output csr_pkg::csr_data_t      rdata
);
    import csr_pkg::*;

    always_comb begin
        rdata = '0;
        case (addr)
            CSR_CRMD:   rdata = crmd;
            CSR_PRMD:   rdata = prmd;
            CSR_ECFG:   rdata = ecfg;
            CSR_ESTAT:  rdata = estat;
            CSR_ERA:    rdata = era;
            CSR_EENTRY: rdata = eentry;
            CSR_TCFG:   rdata = tcfg;
            CSR_TVAL:   rdata = tval;
            // TICLR is write-only, falls through to zero
            default:    rdata = '0;
        endcase
        for (int i = 0; i < N_SAVE; i++) begin
            if (addr == csr_addr_t'(CSR_SAVE0 + i)) begin
                rdata = save[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_top #(
    parameter int N_SAVE = 4
) (
    input  wire                  clk,
    input  wire                  aresetn,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire                  wen,
    input  wire csr_pkg::csr_data_t wdata,
    output csr_pkg::csr_data_t   rdata,
    input  wire                  exception,
    input  wire                  ertn,
    input  wire csr_pkg::ecode_t    ecode_in,
    input  wire csr_pkg::esubcode_t esubcode_in,
    input  wire csr_pkg::csr_data_t era_in,
    input  wire csr_pkg::hw_int_t   hw_int,
    output csr_pkg::plv_t        plv,
    output csr_pkg::csr_data_t   era_out,
    output csr_pkg::csr_data_t   eentry,
    output logic                 cpu_interrupt,
    output logic                 idle_over
);
    import csr_pkg::*;

    csr_data_t crmd;
    csr_data_t prmd;
    csr_data_t ecfg;
    csr_data_t estat;
    csr_data_t tcfg;
    csr_data_t tval;
    csr_data_t save [N_SAVE];
    logic      timer_pending;

    csr_mode mode_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .addr          (addr),
        .wen           (wen),
        .wdata         (wdata),
        .exception     (exception),
        .ertn          (ertn),
        .ecode_in      (ecode_in),
        .esubcode_in   (esubcode_in),
        .hw_int        (hw_int),
        .timer_pending (timer_pending),
        .crmd          (crmd),
        .prmd          (prmd),
        .ecfg          (ecfg),
        .estat         (estat),
        .plv           (plv),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over)
    );

    csr_timer timer_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .addr          (addr),
        .wen           (wen),
        .wdata         (wdata),
        .tcfg          (tcfg),
        .tval          (tval),
        .timer_pending (timer_pending)
    );

    csr_storage #(
        .N_SAVE (N_SAVE)
    ) storage_i (
        .clk       (clk),
        .aresetn   (aresetn),
        .addr      (addr),
        .wen       (wen),
        .wdata     (wdata),
        .exception (exception),
        .era_in    (era_in),
        .era       (era_out),
        .eentry    (eentry),
        .save      (save)
    );

    csr_read_mux #(
        .N_SAVE (N_SAVE)
    ) read_mux_i (
        .addr   (addr),
        .crmd   (crmd),
        .prmd   (prmd),
        .ecfg   (ecfg),
        .estat  (estat),
        .era    (era_out),
        .eentry (eentry),
        .save   (save),
        .tcfg   (tcfg),
        .tval   (tval),
        .rdata  (rdata)
    );

endmodule

`default_nettype wire

// ==== bench/csr_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_properties (
    input wire                     clk,
    input wire                     aresetn,
    input wire                     exception,
    input wire                     ertn,
    input wire                     cpu_interrupt,
    input wire csr_pkg::plv_t      plv,
    input wire csr_pkg::csr_data_t crmd
);
    import csr_pkg::*;

    // Exception entry drops to kernel level with interrupts masked
    exc_enters_kernel: assert property (
        @(posedge clk) disable iff (!aresetn)
        (exception && !ertn) |=> (plv == 2'b00 && !crmd[CRMD_IE])
    ) else $error("exception entry left plv %0d ie %0b", plv, crmd[CRMD_IE]);

    da_pg_exclusive: assert property (
        @(posedge clk) disable iff (!aresetn)
        !(crmd[CRMD_DA] && crmd[CRMD_PG])
    ) else $error("CRMD DA and PG both set");

    // No request while globally masked
    int_needs_ie: assert property (
        @(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd[CRMD_IE]
    ) else $error("cpu_interrupt raised with CRMD.IE clear");

endmodule

`default_nettype wire

// ==== bench/csr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_tb;
    import csr_pkg::*;

    localparam int n_save        = 4;
    localparam int len_reset     = 10;
    localparam int len_readback  = 200;
    localparam int len_crmd      = 100;
    localparam int len_exception = 150;
    localparam int len_interrupt = 150;
    localparam int len_timer     = 260;
    localparam int cycle_limit   = (len_reset + len_readback + len_crmd + len_exception
                                    + len_interrupt + len_timer) * 3 / 2;

    logic       clk;
    logic       aresetn;
    csr_addr_t  addr;
    logic       wen;
    csr_data_t  wdata;
    csr_data_t  rdata;
    logic       exception;
    logic       ertn;
    ecode_t     ecode_in;
    esubcode_t  esubcode_in;
    csr_data_t  era_in;
    hw_int_t    hw_int;
    plv_t       plv;
    csr_data_t  era_out;
    csr_data_t  eentry;
    logic       cpu_interrupt;
    logic       idle_over;

    // Reference model state
    logic [1:0]  m_plv;
    logic        m_ie;
    logic        m_da;
    logic        m_pg;
    logic [1:0]  m_datf;
    logic [1:0]  m_datm;
    logic [1:0]  m_pplv;
    logic        m_pie;
    logic [12:0] m_lie;
    logic [1:0]  m_soft;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_eentry;
    logic [31:0] m_save [n_save];
    logic        m_en;
    logic        m_per;
    logic [29:0] m_initval;
    logic [31:0] m_tval;
    logic        m_pend;

    integer seed;
    int     cycles;
    int     checks;
    int     errors;
    int     tests;
    int     test_start_cycle;
    int     test_start_errors;
    string  cur_test;

    csr_top #(
        .N_SAVE (n_save)
    ) dut_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .addr          (addr),
        .wen           (wen),
        .wdata         (wdata),
        .rdata         (rdata),
        .exception     (exception),
        .ertn          (ertn),
        .ecode_in      (ecode_in),
        .esubcode_in   (esubcode_in),
        .era_in        (era_in),
        .hw_int        (hw_int),
        .plv           (plv),
        .era_out       (era_out),
        .eentry        (eentry),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over)
    );

    bind csr_top csr_properties props_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .exception     (exception),
        .ertn          (ertn),
        .cpu_interrupt (cpu_interrupt),
        .plv           (plv),
        .crmd          (crmd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    function automatic int pick(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r % n);
    endfunction

    function automatic logic [12:0] exp_is();
        return {1'b0, m_pend, 1'b0, hw_int, m_soft};
    endfunction

    function automatic logic [31:0] exp_read(input csr_addr_t a);
        int sidx;
        sidx = int'(a) - int'(CSR_SAVE0);
        if (sidx >= 0 && sidx < n_save) begin
            return m_save[sidx[1:0]];
        end
        case (a)
            CSR_CRMD:   return {23'b0, m_datm, m_datf, m_pg, m_da, m_ie, m_plv};
            CSR_PRMD:   return {29'b0, m_pie, m_pplv};
            CSR_ECFG:   return {19'b0, m_lie};
            CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b0, exp_is()};
            CSR_ERA:    return m_era;
            CSR_EENTRY: return m_eentry;
            CSR_TCFG:   return {m_initval, m_per, m_en};
            CSR_TVAL:   return m_tval;
            default:    return 32'h0;
        endcase
    endfunction

    function automatic csr_addr_t unmapped_addr();
        logic [31:0] r;
        csr_addr_t   a;
        r = next_rand();
        a = r[13:0];
        if (a == CSR_CRMD || a == CSR_PRMD || a == CSR_ECFG || a == CSR_ESTAT ||
            a == CSR_ERA || a == CSR_EENTRY || a == CSR_TCFG || a == CSR_TVAL ||
            (int'(a) >= int'(CSR_SAVE0) && int'(a) < int'(CSR_SAVE0) + n_save)) begin
            a = 14'h3fff;
        end
        return a;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic reset_model();
        m_plv     = '0;
        m_ie      = 1'b0;
        m_da      = 1'b1;
        m_pg      = 1'b0;
        m_datf    = '0;
        m_datm    = '0;
        m_pplv    = '0;
        m_pie     = 1'b0;
        m_lie     = '0;
        m_soft    = '0;
        m_ecode   = '0;
        m_esub    = '0;
        m_era     = '0;
        m_eentry  = '0;
        m_en      = 1'b0;
        m_per     = 1'b0;
        m_initval = '0;
        m_tval    = '0;
        m_pend    = 1'b0;
        for (int i = 0; i < n_save; i++) begin
            m_save[i] = '0;
        end
    endtask

    // One clock edge of the reference model, old state in, new state out
    task automatic model_update();
        logic       tcfg_wr;
        logic       expire;
        int         sidx;
        logic [1:0] old_pplv;
        logic       old_pie;
        tcfg_wr  = wen && addr == CSR_TCFG;
        expire   = m_en && m_tval == 32'd1 && !tcfg_wr;
        sidx     = int'(addr) - int'(CSR_SAVE0);
        old_pplv = m_pplv;
        old_pie  = m_pie;
        if (!aresetn) begin
            reset_model();
        end else begin
            if (expire) begin
                m_pend = 1'b1;
            end else if (wen && addr == CSR_TICLR && wdata[0]) begin
                m_pend = 1'b0;
            end
            if (tcfg_wr) begin
                m_tval = (wdata & 32'hffff_fffc) + 32'd1;
            end else if (m_tval == 32'd0) begin
                if (m_per) begin
                    m_tval = {m_initval, 2'b00} + 32'd1;
                end
            end else if (m_en) begin
                m_tval = m_tval - 32'd1;
            end
            if (tcfg_wr) begin
                m_en      = wdata[0];
                m_per     = wdata[1];
                m_initval = wdata[31:2];
            end
            // PRMD takes the mode from before this edge
            if (exception) begin
                m_pplv = m_plv;
                m_pie  = m_ie;
            end else if (wen && addr == CSR_PRMD) begin
                m_pplv = wdata[1:0];
                m_pie  = wdata[2];
            end
            if (ertn) begin
                m_plv = old_pplv;
                m_ie  = old_pie;
            end else if (exception) begin
                m_plv = '0;
                m_ie  = 1'b0;
            end else if (wen && addr == CSR_CRMD) begin
                m_plv  = wdata[1:0];
                m_ie   = wdata[2];
                m_datf = wdata[6:5];
                m_datm = wdata[8:7];
                if (wdata[3] != wdata[4]) begin
                    m_da = wdata[3];
                    m_pg = wdata[4];
                end
            end
            if (exception) begin
                m_ecode = ecode_in;
                m_esub  = (ecode_in == 6'd0) ? 9'd0 : esubcode_in;
                m_era   = era_in;
            end else if (wen && addr == CSR_ERA) begin
                m_era = wdata;
            end
            if (wen && addr == CSR_ECFG) begin
                m_lie = wdata[12:0];
            end
            if (wen && addr == CSR_ESTAT) begin
                m_soft = wdata[1:0];
            end
            if (wen && addr == CSR_EENTRY) begin
                m_eentry = {wdata[31:6], 6'b0};
            end
            if (wen && sidx >= 0 && sidx < n_save) begin
                m_save[sidx[1:0]] = wdata;
            end
        end
    endtask

    task automatic compare_outputs();
        check("rdata", exp_read(addr), rdata);
        check("plv", {30'b0, m_plv}, {30'b0, plv});
        check("era_out", m_era, era_out);
        check("eentry", m_eentry, eentry);
        check("cpu_interrupt", {31'b0, m_ie & (|(m_lie & exp_is()))}, {31'b0, cpu_interrupt});
        check("idle_over", {31'b0, |exp_is()}, {31'b0, idle_over});
    endtask

    task automatic step();
        @(posedge clk);
        model_update();
        @(negedge clk);
        compare_outputs();
    endtask

    // Read check after an address change, once the mux has settled
    task automatic peek(input string what, input logic [31:0] exp, input logic [31:0] mask);
        #1;
        check(what, exp & mask, rdata & mask);
    endtask

    task automatic count_down(input int load);
        for (int i = 1; i <= load; i++) begin
            step();
            check("tval_count", 32'(load - i), rdata);
        end
    endtask

    task automatic write_reg(input csr_addr_t a, input logic [31:0] d);
        addr  = a;
        wen   = 1'b1;
        wdata = d;
        step();
        wen = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test          = name;
        test_start_cycle  = cycles;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%s finished: %0d cycles, %0d errors", cur_test,
                 cycles - test_start_cycle, errors - test_start_errors);
    endtask

    task automatic timer_round(input logic periodic, input int reloads);
        int k;
        int load;
        k    = pick(8);
        load = k * 4 + 1;
        write_reg(CSR_TCFG, (32'(k) << 2) | {30'b0, periodic, 1'b1});
        addr = CSR_TVAL;
        peek("tval_load", 32'(load), 32'hffff_ffff);
        count_down(load);
        addr = CSR_ESTAT;
        peek("pending_set", 32'h800, 32'h800);
        for (int n = 0; n <= reloads; n++) begin
            write_reg(CSR_TICLR, 32'h1);
            addr = CSR_ESTAT;
            peek("pending_clear", 32'h0, 32'h800);
            if (n < reloads) begin
                addr = CSR_TVAL;
                peek("tval_reload", 32'(load), 32'hffff_ffff);
                count_down(load);
                addr = CSR_ESTAT;
                peek("pending_again", 32'h800, 32'h800);
            end
        end
    endtask

    initial begin
        int          sel;
        logic [31:0] r;
        seed        = 67875;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        aresetn     = 1'b0;
        addr        = CSR_CRMD;
        wen         = 1'b0;
        wdata       = '0;
        exception   = 1'b0;
        ertn        = 1'b0;
        ecode_in    = '0;
        esubcode_in = '0;
        era_in      = '0;
        hw_int      = '0;
        reset_model();

        begin_test("reset");
        repeat (len_reset) step();
        aresetn = 1'b1;
        end_test();

        begin_test("readback");
        for (int n = 0; n < len_readback; n++) begin
            sel = pick(10);
            case (sel)
                0: addr = CSR_ERA;
                1: addr = CSR_EENTRY;
                2, 3, 4, 5: addr = CSR_SAVE0 + 14'(sel - 2);
                6: addr = CSR_ECFG;
                7: addr = CSR_PRMD;
                8: addr = unmapped_addr();
                default: addr = CSR_TICLR;
            endcase
            wen   = pick(2) == 1;
            wdata = next_rand();
            step();
        end
        wen = 1'b0;
        end_test();

        begin_test("crmd_write");
        addr = CSR_CRMD;
        for (int n = 0; n < len_crmd; n++) begin
            wen   = pick(4) != 0;
            wdata = next_rand();
            step();
        end
        wen = 1'b0;
        end_test();

        begin_test("exception");
        for (int n = 0; n < len_exception; n++) begin
            r           = next_rand();
            exception   = pick(4) == 0;
            ertn        = pick(5) == 0;
            ecode_in    = (pick(8) == 0) ? 6'd0 : r[5:0];
            esubcode_in = r[14:6];
            era_in      = next_rand();
            wen         = pick(8) < 2;
            wdata       = next_rand();
            case (pick(4))
                0: addr = CSR_CRMD;
                1: addr = CSR_PRMD;
                2: addr = CSR_ERA;
                default: addr = CSR_ESTAT;
            endcase
            step();
        end
        exception = 1'b0;
        ertn      = 1'b0;
        wen       = 1'b0;
        end_test();

        begin_test("interrupt");
        for (int n = 0; n < len_interrupt; n++) begin
            r      = next_rand();
            hw_int = (pick(3) == 0) ? r[7:0] : 8'h0;
            sel    = pick(6);
            wen    = sel < 3;
            wdata  = next_rand();
            case (sel)
                1: addr = CSR_ECFG;
                2: addr = CSR_CRMD;
                default: addr = CSR_ESTAT;
            endcase
            step();
        end
        hw_int = '0;
        write_reg(CSR_ESTAT, 32'h0);
        end_test();

        begin_test("timer");
        for (int n = 0; n < 4; n++) begin
            timer_round(1'b0, 0);
        end
        timer_round(1'b1, 2);
        write_reg(CSR_TCFG, 32'h0);
        write_reg(CSR_TICLR, 32'h1);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/csr_pkg.sv
verilog/csr_mode.sv
verilog/csr_timer.sv
verilog/csr_storage.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
bench/csr_properties.sv
bench/csr_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f --top-module csr_tb -o csr_sim
./obj_dir/csr_sim 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"
